// ==== design/cdc_timer_defs.svh ====
// Widths and synchronizer depth shared by the CDC timer RTL
// Include before any declaration that sizes a bus or counter
`ifndef CDC_TIMER_DEFS_SVH
`define CDC_TIMER_DEFS_SVH

// Synchronizer stages in the destination domain
`define DEST_SYNC_FF 4

// APB bus
`define APB_ADDR_W 8
`define APB_DATA_W 32

// Timer datapath
`define PERIOD_W 16
`define COUNT_W 16

`endif

// ==== design/apb_regs_pkg.sv ====
// Register map and control word layout of the APB timer block
`default_nettype none

package apb_regs_pkg;

`include "cdc_timer_defs.svh"

    // Byte offsets seen on paddr
    typedef enum logic [`APB_ADDR_W-1:0] {
        REG_CTRL   = 8'h00,  // Enable and mode
        REG_PERIOD = 8'h04,  // Tick period in dest_clk cycles
        REG_CMD    = 8'h08,  // Bit 0 requests a restart
        REG_COUNT  = 8'h0C,  // Ticks since last restart
        REG_STATUS = 8'h10   // Bit 0 is busy
    } timer_reg_e;

    // CTRL bit 1 is mode, bit 0 is enable
    typedef struct packed {
        logic mode;
        logic enable;
    } timer_ctrl_t;

endpackage

`default_nettype wire

// ==== design/timer_pkg.sv ====
// Timer mode and FSM state encodings used on both sides of the crossing
`default_nettype none

package timer_pkg;

    // Selected through CTRL bit 1
    typedef enum logic {
        TIMER_PERIODIC = 1'b0,
        TIMER_ONESHOT  = 1'b1
    } timer_mode_e;

    // Core FSM
    typedef enum logic [1:0] {
        TMR_IDLE = 2'd0,  // Disabled
        TMR_RUN  = 2'd1,  // Counting down
        TMR_DONE = 2'd2   // One-shot has fired
    } timer_state_e;

endpackage

`default_nettype wire

// ==== design/timer_cfg_if.sv ====
// Configuration and status bundle, one instance per clock domain
// The pclk side carries the restart toggle, the dest_clk side the pulse
`timescale 1ns/1ps
`default_nettype none

`include "cdc_timer_defs.svh"

interface timer_cfg_if import timer_pkg::*; ();

    logic                 enable;
    timer_mode_e          mode;
    logic [`PERIOD_W-1:0] period;
    logic                 restart_tgl;  // Flips once per restart command
    logic                 restart;      // Single-cycle pulse
    logic [`COUNT_W-1:0]  count_gray;
    logic                 busy;

    // pclk domain
    modport regs       (output enable, mode, period, restart_tgl,
                        input  count_gray, busy);
    modport bridge_src (input  enable, mode, period, restart_tgl,
                        output count_gray, busy);

    // dest_clk domain
    modport bridge_dst (output enable, mode, period, restart,
                        input  count_gray, busy);
    modport core       (input  enable, mode, period, restart,
                        output count_gray, busy);

endinterface

`default_nettype wire

// ==== design/cdc_array_single.sv ====
// Multi-bit level synchronizer for quasi-static or Gray-coded buses
// Optional source register, then a chain of DEST_SYNC_FF flops on dest_clk
`timescale 1ns/1ps
`default_nettype none

`include "cdc_timer_defs.svh"

module cdc_array_single #(
    parameter int WIDTH         = 1,
    parameter int DEST_SYNC_FF  = `DEST_SYNC_FF,
    parameter int SRC_INPUT_REG = 1
) (
    input  wire logic             src_clk,
    input  wire logic [WIDTH-1:0] src_in,
    input  wire logic             dest_clk,
    output logic      [WIDTH-1:0] dest_out
);

    logic [WIDTH-1:0] src_q;  // Value presented to the first sync stage

    if (SRC_INPUT_REG != 0) begin : g_src_reg
        always_ff @(posedge src_clk) begin
            src_q <= src_in;  // Removes source-side combinational glitches
        end
    end else begin : g_src_pass
        assign src_q = src_in;
    end

    (* ASYNC_REG = "TRUE" *)
    logic [DEST_SYNC_FF-1:0][WIDTH-1:0] sync_q;

    always_ff @(posedge dest_clk) begin
        sync_q[0] <= src_q;  // Metastable stage
        for (int i = 1; i < DEST_SYNC_FF; i++) begin
            sync_q[i] <= sync_q[i-1];
        end
    end

    assign dest_out = sync_q[DEST_SYNC_FF-1];

endmodule

`default_nettype wire

// ==== design/apb_timer_regs.sv ====
// APB slave on pclk with zero wait states for the timer registers
// Drives the pclk side of the config bundle and decodes the Gray count
`timescale 1ns/1ps
`default_nettype none

`include "cdc_timer_defs.svh"

module apb_timer_regs import apb_regs_pkg::*, timer_pkg::*; (
    input  wire logic                   pclk,
    input  wire logic                   arst_n,
    input  wire logic                   psel,
    input  wire logic                   penable,
    input  wire logic                   pwrite,
    input  wire logic [`APB_ADDR_W-1:0] paddr,
    input  wire logic [`APB_DATA_W-1:0] pwdata,
    output logic      [`APB_DATA_W-1:0] prdata,
    output logic                        pready,
    output logic                        pslverr,
    timer_cfg_if.regs                   cfg
);

    timer_ctrl_t          ctrl_q;
    logic [`PERIOD_W-1:0] period_q;
    logic                 tgl_q;
    logic                 access;
    logic                 addr_ok;
    logic                 read_only;
    logic                 wr_ok;
    logic [`COUNT_W-1:0]  count_bin;
    timer_reg_e           reg_sel;

    assign access  = psel & penable;  // Access phase
    assign reg_sel = timer_reg_e'(paddr);

    always_comb begin
        addr_ok   = 1'b1;
        read_only = 1'b0;
        case (reg_sel)
            REG_CTRL, REG_PERIOD, REG_CMD: ;
            REG_COUNT, REG_STATUS:         read_only = 1'b1;
            default:                       addr_ok   = 1'b0;
        endcase
    end

    assign wr_ok   = access & pwrite & addr_ok & ~read_only;
    assign pslverr = access & (~addr_ok | (pwrite & read_only));
    assign pready  = 1'b1;  // No wait states

    // Writes land on the edge that closes the access phase
    always_ff @(posedge pclk or negedge arst_n) begin
        if (!arst_n) begin
            ctrl_q   <= '0;
            period_q <= '0;
            tgl_q    <= 1'b0;
        end else if (wr_ok) begin
            case (reg_sel)
                REG_CTRL:   ctrl_q   <= timer_ctrl_t'(pwdata[1:0]);
                REG_PERIOD: period_q <= pwdata[`PERIOD_W-1:0];
                REG_CMD: begin
                    if (pwdata[0]) begin
                        tgl_q <= ~tgl_q;  // Bridge turns each flip into a pulse
                    end
                end
                default: ;
            endcase
        end
    end

    // Gray to binary, MSB first
    always_comb begin
        count_bin[`COUNT_W-1] = cfg.count_gray[`COUNT_W-1];
        for (int i = `COUNT_W - 2; i >= 0; i--) begin
            count_bin[i] = count_bin[i+1] ^ cfg.count_gray[i];
        end
    end

    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            case (reg_sel)
                REG_CTRL:   prdata[1:0]           = ctrl_q;
                REG_PERIOD: prdata[`PERIOD_W-1:0] = period_q;
                REG_COUNT:  prdata[`COUNT_W-1:0]  = count_bin;
                REG_STATUS: prdata[0]             = cfg.busy;
                default: ;  // CMD reads as zero
            endcase
        end
    end

    assign cfg.enable      = ctrl_q.enable;
    assign cfg.mode        = timer_mode_e'(ctrl_q.mode);
    assign cfg.period      = period_q;
    assign cfg.restart_tgl = tgl_q;

endmodule

`default_nettype wire

// ==== design/timer_cdc_bridge.sv ====
// Every crossing between the pclk register block and the dest_clk core
// Config and restart toggle go forward, Gray count and busy come back
`timescale 1ns/1ps
`default_nettype none

`include "cdc_timer_defs.svh"

module timer_cdc_bridge import timer_pkg::*; (
    input  wire logic       pclk,
    input  wire logic       dest_clk,
    input  wire logic       arst_n,
    timer_cfg_if.bridge_src src,
    timer_cfg_if.bridge_dst dst
);

    localparam int FWD_W = `PERIOD_W + 3;  // Toggle, period, mode, enable

    logic [FWD_W-1:0] fwd_src;
    logic [FWD_W-1:0] fwd_dst;
    logic             tgl_sync;
    logic             tgl_q;

    // Static while the timer is disabled, toggle moves one bit at a time
    assign fwd_src = {src.restart_tgl, src.period, src.mode, src.enable};

    cdc_array_single #(
        .WIDTH         (FWD_W),
        .DEST_SYNC_FF  (`DEST_SYNC_FF),
        .SRC_INPUT_REG (1)
    ) u_sync_cfg (
        .src_clk  (pclk),
        .src_in   (fwd_src),
        .dest_clk (dest_clk),
        .dest_out (fwd_dst)
    );

    assign dst.enable = fwd_dst[0];
    assign dst.mode   = timer_mode_e'(fwd_dst[1]);
    assign dst.period = fwd_dst[2 +: `PERIOD_W];
    assign tgl_sync   = fwd_dst[FWD_W-1];

    always_ff @(posedge dest_clk or negedge arst_n) begin
        if (!arst_n) begin
            tgl_q <= 1'b0;
        end else begin
            tgl_q <= tgl_sync;  // Last seen toggle level
        end
    end

    assign dst.restart = tgl_sync ^ tgl_q;  // One pulse per flip

    // Core registers count_gray, so no extra source stage here
    cdc_array_single #(
        .WIDTH         (`COUNT_W),
        .DEST_SYNC_FF  (`DEST_SYNC_FF),
        .SRC_INPUT_REG (0)
    ) u_sync_count (
        .src_clk  (dest_clk),
        .src_in   (dst.count_gray),
        .dest_clk (pclk),
        .dest_out (src.count_gray)
    );

    cdc_array_single #(
        .WIDTH         (1),
        .DEST_SYNC_FF  (`DEST_SYNC_FF),
        .SRC_INPUT_REG (0)
    ) u_sync_busy (
        .src_clk  (dest_clk),
        .src_in   (dst.busy),
        .dest_clk (pclk),
        .dest_out (src.busy)
    );

endmodule

`default_nettype wire

// ==== design/pulse_timer_core.sv ====
// Tick generator on dest_clk with periodic and one-shot modes
// Publishes the tick count in Gray code for the return crossing
`timescale 1ns/1ps
`default_nettype none

`include "cdc_timer_defs.svh"

module pulse_timer_core import timer_pkg::*; (
    input  wire logic dest_clk,
    input  wire logic arst_n,
    timer_cfg_if.core cfg,
    output logic      tick
);

    timer_state_e         state_q;
    logic [`PERIOD_W-1:0] down_q;
    logic [`PERIOD_W-1:0] period_eff;
    logic [`PERIOD_W-1:0] reload;
    logic [`COUNT_W-1:0]  count_q;
    logic [`COUNT_W-1:0]  gray_q;
    logic                 tick_q;

    // Floor of 2 keeps Gray updates two cycles apart
    assign period_eff = (cfg.period < 2) ? `PERIOD_W'(2) : cfg.period;
    assign reload     = period_eff - 1'b1;

    always_ff @(posedge dest_clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= TMR_IDLE;
            down_q  <= '0;
            count_q <= '0;
            gray_q  <= '0;
            tick_q  <= 1'b0;
        end else begin
            tick_q <= 1'b0;
            gray_q <= count_q ^ (count_q >> 1);
            if (cfg.restart) begin
                count_q <= '0;
                down_q  <= reload;
                state_q <= cfg.enable ? TMR_RUN : TMR_IDLE;
            end else begin
                case (state_q)
                    TMR_IDLE: begin
                        if (cfg.enable) begin
                            state_q <= TMR_RUN;
                            down_q  <= reload;  // First tick P cycles on
                        end
                    end
                    TMR_RUN: begin
                        if (!cfg.enable) begin
                            state_q <= TMR_IDLE;
                        end else if (down_q == '0) begin
                            tick_q  <= 1'b1;
                            count_q <= count_q + 1'b1;
                            down_q  <= reload;
                            if (cfg.mode == TIMER_ONESHOT) begin
                                state_q <= TMR_DONE;
                            end
                        end else begin
                            down_q <= down_q - 1'b1;
                        end
                    end
                    TMR_DONE: begin
                        if (!cfg.enable) begin
                            state_q <= TMR_IDLE;  // Wait for re-arm
                        end
                    end
                    default: state_q <= TMR_IDLE;
                endcase
            end
        end
    end

    assign cfg.busy       = (state_q == TMR_RUN);
    assign cfg.count_gray = gray_q;
    assign tick           = tick_q;

endmodule

`default_nettype wire

// ==== design/cdc_timer_top.sv ====
// Top level of the CDC timer with APB on pclk and tick outputs on dest_clk
`timescale 1ns/1ps
`default_nettype none

`include "cdc_timer_defs.svh"

module cdc_timer_top (
    input  wire logic                   pclk,
    input  wire logic                   dest_clk,
    input  wire logic                   arst_n,
    input  wire logic                   psel,
    input  wire logic                   penable,
    input  wire logic                   pwrite,
    input  wire logic [`APB_ADDR_W-1:0] paddr,
    input  wire logic [`APB_DATA_W-1:0] pwdata,
    output logic      [`APB_DATA_W-1:0] prdata,
    output logic                        pready,
    output logic                        pslverr,
    output logic                        tick,
    output logic                        busy
);

    timer_cfg_if cfg_src ();  // pclk side
    timer_cfg_if cfg_dst ();  // dest_clk side

    apb_timer_regs u_regs (
        .pclk    (pclk),
        .arst_n  (arst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .cfg     (cfg_src.regs)
    );

    timer_cdc_bridge u_bridge (
        .pclk     (pclk),
        .dest_clk (dest_clk),
        .arst_n   (arst_n),
        .src      (cfg_src.bridge_src),
        .dst      (cfg_dst.bridge_dst)
    );

    pulse_timer_core u_core (
        .dest_clk (dest_clk),
        .arst_n   (arst_n),
        .cfg      (cfg_dst.core),
        .tick     (tick)
    );

    assign busy = cfg_dst.busy;  // Unsynchronized, dest_clk domain

endmodule

`default_nettype wire

// ==== test/tb_clkgen.sv ====
// Testbench clock source with a reset held low for a number of cycles
// One instance per clock domain
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
    parameter real PERIOD_NS    = 8.0,
    parameter int  RESET_CYCLES = 16
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;  // Released away from the active edge
    end

endmodule

`default_nettype wire

// ==== test/tb_cdc_timer.sv ====
// Directed testbench for the CDC timer, APB on pclk and ticks on dest_clk
// Runs reset, register, periodic, one-shot, restart and minimum period tests
`timescale 1ns/1ps
`default_nettype none

`include "cdc_timer_defs.svh"

module tb_cdc_timer import apb_regs_pkg::*; ();

    localparam int MAX_P       = 80;
    localparam int TICKS_TEST  = 10;
    localparam int N_TESTS     = 6;
    localparam int WATCHDOG_NS = N_TESTS * TICKS_TEST * MAX_P * 11 + 20000;

    logic                   pclk;
    logic                   dest_clk;
    logic                   arst_n;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [`APB_ADDR_W-1:0] paddr;
    logic [`APB_DATA_W-1:0] pwdata;
    logic [`APB_DATA_W-1:0] prdata;
    logic                   pready;
    logic                   pslverr;
    logic                   tick;
    logic                   busy;
    logic [31:0]            lfsr_state;
    int                     tick_total;

    tb_clkgen #(.PERIOD_NS(8.0), .RESET_CYCLES(16)) u_pclk_gen (
        .clk(pclk), .rst_n(arst_n));
    tb_clkgen #(.PERIOD_NS(11.0), .RESET_CYCLES(16)) u_dclk_gen (
        .clk(dest_clk), .rst_n());

    cdc_timer_top uut (
        .pclk(pclk), .dest_clk(dest_clk), .arst_n(arst_n),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata),
        .pready(pready), .pslverr(pslverr), .tick(tick), .busy(busy)
    );

    // Counts every tick the DUT emits
    always @(negedge dest_clk) begin
        if (arst_n && tick) begin
            tick_total <= tick_total + 1;
        end
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v[i] = lfsr_state[0];  // One step per bit
        end
    endtask

    task automatic check_eq(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0d ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
            $display(">>> FAIL");
            $fatal(1);
        end
    endtask

    task automatic fail_now(input string msg);
        $display("%s at %0d ns", msg, $time);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic apb_xfer(input logic wr, input logic [`APB_ADDR_W-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
        @(negedge pclk);
        psel    = 1'b1;  // Setup phase
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge pclk);
        penable = 1'b1;
        #2;
        rdata = prdata;  // Stable mid access phase
        err   = pslverr;
        check_eq("pready", pready, 1);
        @(negedge pclk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [`APB_ADDR_W-1:0] addr, input logic [31:0] data,
                             input logic exp_err);
        logic [31:0] unused;
        logic        err;
        apb_xfer(1'b1, addr, data, unused, err);
        check_eq("pslverr on write", err, exp_err);
    endtask

    task automatic apb_read(input logic [`APB_ADDR_W-1:0] addr, output logic [31:0] data,
                            input logic exp_err);
        logic err;
        apb_xfer(1'b0, addr, '0, data, err);
        check_eq("pslverr on read", err, exp_err);
    endtask

    task automatic wait_pclk(input int n);
        repeat (n) @(negedge pclk);
    endtask

    task automatic wait_tick(input int limit, output int cycles);
        cycles = 0;
        do begin
            @(negedge dest_clk);
            cycles++;
        end while (!tick && cycles < limit);
        if (!tick) fail_now("No tick arrived within the expected window");
    endtask

    task automatic wait_busy_low();
        int n;
        n = 0;
        while (busy && n < 40) begin
            @(negedge dest_clk);
            n++;
        end
        if (busy) fail_now("busy stayed high after the timer was disabled");
    endtask

    // Disable and clear the count so each test starts from zero
    task automatic restart_idle();
        apb_write(REG_CTRL, 32'h0, 1'b0);
        wait_busy_low();
        apb_write(REG_CMD, 32'h1, 1'b0);
        wait_pclk(20);
    endtask

    task automatic test_reset_state();
        logic [31:0] d;
        apb_read(REG_CTRL, d, 1'b0);
        check_eq("CTRL", d, 0);
        apb_read(REG_PERIOD, d, 1'b0);
        check_eq("PERIOD", d, 0);
        apb_read(REG_COUNT, d, 1'b0);
        check_eq("COUNT", d, 0);
        apb_read(REG_STATUS, d, 1'b0);
        check_eq("STATUS", d, 0);
        @(negedge dest_clk);
        check_eq("tick", tick, 0);
        check_eq("busy", busy, 0);
    endtask

    task automatic test_register_access();
        logic [31:0] pv;
        logic [31:0] cv;
        logic [31:0] d;
        rand_bits(16, pv);
        rand_bits(2, cv);
        apb_write(REG_PERIOD, pv, 1'b0);
        apb_read(REG_PERIOD, d, 1'b0);
        check_eq("PERIOD readback", d, pv);
        apb_write(REG_CTRL, cv, 1'b0);
        apb_read(REG_CTRL, d, 1'b0);
        check_eq("CTRL readback", d, cv);
        apb_write(REG_CTRL, 32'h0, 1'b0);
        rand_bits(32, d);
        apb_write(8'h14, d, 1'b1);  // Unmapped
        apb_read(8'h20, d, 1'b1);
        apb_write(REG_COUNT, 32'h5, 1'b1);
        apb_write(REG_STATUS, 32'h1, 1'b1);
    endtask

    task automatic test_periodic();
        logic [31:0] r;
        logic [31:0] d;
        int          p;
        int          c;
        int          base;
        rand_bits(6, r);
        p = 4 + r;
        restart_idle();
        apb_write(REG_PERIOD, p, 1'b0);
        base = tick_total;
        apb_write(REG_CTRL, 32'h1, 1'b0);
        wait_tick(p + 20, c);
        for (int i = 0; i < 4; i++) begin
            wait_tick(p + 4, c);
            check_eq("periodic tick spacing", c, p);
        end
        apb_read(REG_STATUS, d, 1'b0);
        check_eq("STATUS while running", d, 1);
        apb_write(REG_CTRL, 32'h0, 1'b0);
        wait_busy_low();
        wait_pclk(10);
        apb_read(REG_COUNT, d, 1'b0);
        check_eq("COUNT after periodic run", d, tick_total - base);
    endtask

    task automatic test_oneshot();
        logic [31:0] r;
        logic [31:0] d;
        logic        saw_busy;
        int          p;
        int          n;
        int          base;
        rand_bits(6, r);
        p = 4 + r;
        restart_idle();
        apb_write(REG_PERIOD, p, 1'b0);
        base     = tick_total;
        saw_busy = 1'b0;
        n        = 0;
        apb_write(REG_CTRL, 32'h3, 1'b0);  // One-shot, enabled
        do begin
            @(negedge dest_clk);
            n++;
            if (busy) saw_busy = 1'b1;
        end while (!tick && n < p + 16);
        if (!tick) fail_now("One-shot timer never ticked");
        check_eq("busy before one-shot tick", saw_busy, 1);
        @(negedge dest_clk);
        check_eq("busy after one-shot tick", busy, 0);
        repeat (p + 10) @(negedge dest_clk);
        check_eq("one-shot tick count", tick_total - base, 1);
        wait_pclk(10);
        apb_read(REG_STATUS, d, 1'b0);
        check_eq("STATUS after one-shot", d, 0);
        apb_read(REG_COUNT, d, 1'b0);
        check_eq("COUNT after one-shot", d, 1);
        apb_write(REG_CTRL, 32'h0, 1'b0);
    endtask

    task automatic test_restart();
        logic [31:0] r;
        logic [31:0] d;
        int          p;
        int          c;
        int          base;
        rand_bits(6, r);
        p = 16 + r;
        restart_idle();
        apb_write(REG_PERIOD, p, 1'b0);
        apb_write(REG_CTRL, 32'h1, 1'b0);
        wait_tick(p + 20, c);
        wait_tick(p + 4, c);
        restart_idle();
        apb_read(REG_COUNT, d, 1'b0);
        check_eq("COUNT after idle restart", d, 0);
        apb_write(REG_CTRL, 32'h1, 1'b0);
        wait_tick(p + 20, c);
        apb_write(REG_CMD, 32'h1, 1'b0);  // Restart while running
        repeat (12) @(negedge dest_clk);
        base = tick_total;
        wait_tick(p + 4, c);  // Partial interval after the reload
        for (int i = 0; i < 2; i++) begin
            wait_tick(p + 4, c);
            check_eq("tick spacing after restart", c, p);
        end
        apb_write(REG_CTRL, 32'h0, 1'b0);
        wait_busy_low();
        wait_pclk(10);
        apb_read(REG_COUNT, d, 1'b0);
        check_eq("COUNT after running restart", d, tick_total - base);
    endtask

    task automatic test_min_period();
        int c;
        for (int v = 0; v < 2; v++) begin
            restart_idle();
            apb_write(REG_PERIOD, v, 1'b0);
            apb_write(REG_CTRL, 32'h1, 1'b0);
            wait_tick(30, c);
            for (int i = 0; i < 2; i++) begin
                wait_tick(4, c);
                check_eq("minimum period spacing", c, 2);
            end
            apb_write(REG_CTRL, 32'h0, 1'b0);
            wait_busy_low();
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
        $display(">>> FAIL");
        $fatal(1);
    end

    initial begin
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        lfsr_state = 32'h91df9dc8;
        tick_total = 0;
        @(posedge arst_n);
        wait_pclk(4);
        test_reset_state();
        test_register_access();
        test_periodic();
        test_oneshot();
        test_restart();
        test_min_period();
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+design
design/apb_regs_pkg.sv
design/timer_pkg.sv
design/timer_cfg_if.sv
design/cdc_array_single.sv
design/apb_timer_regs.sv
design/timer_cdc_bridge.sv
design/pulse_timer_core.sv
design/cdc_timer_top.sv
test/tb_clkgen.sv
test/tb_cdc_timer.sv

// ==== Bender.yml ====
package:
  name: cdc_timer

sources:
  - include_dirs:
      - design
    files:
      - design/apb_regs_pkg.sv
      - design/timer_pkg.sv
      - design/timer_cfg_if.sv
      - design/cdc_array_single.sv
      - design/apb_timer_regs.sv
      - design/timer_cdc_bridge.sv
      - design/pulse_timer_core.sv
      - design/cdc_timer_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - test/tb_clkgen.sv
      - test/tb_cdc_timer.sv
